// File: verilog.f
hdl/dbg_pkg.sv
hdl/dbg_command_fsm.sv
hdl/dbg_instr_loader.sv
hdl/dbg_dump_sequencer.sv
hdl/dbg_tx_serializer.sv
hdl/debug_unit.sv
testbench/tb_mips_model.sv
testbench/tb_debug_unit.sv

// File: Makefile
SIM      = verilator
TOP      = tb_debug_unit
FILELIST = verilog.f
BUILD    = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD)
LOG      = sim.log
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit
    import dbg_pkg::*;
();

    localparam int                IMEM_ADDR_W = 8;
    localparam int                DATA_WORDS  = 16;
    localparam int                MEM_ADDR_W  = $clog2(DATA_WORDS);
    localparam logic [WORD_W-1:0] HALT_PC     = 32'd24;
    localparam int                DUMP_BYTES  = (2 + NUM_REGS + DATA_WORDS) * 4;
    localparam int                TIMEOUT     = 5000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  core_reset;
    uart_rx_t              uart_rx;
    logic                  rx_ack;
    uart_tx_t              uart_tx;
    logic                  tx_done;
    imem_wr_t              imem_wr;
    core_status_t          core;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [WORD_W-1:0]     reg_data;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0]     mem_data;
    logic                  core_clk_en;

    integer            seed = 32'hff4a4342;
    int                errors = 0;
    int                timeouts = 0;
    logic [7:0]        exp_q[$];      // Reference dump bytes still to arrive
    logic [7:0]        wr_addr_q[$];
    logic [WORD_W-1:0] wr_data_q[$];
    logic              tx_busy;       // Between a start and its done
    int                tx_bytes;
    int                en_cnt;
    int                wr_cnt;

    always #5 clk = ~clk;

    debug_unit #(.IMEM_ADDR_W(IMEM_ADDR_W), .DATA_WORDS(DATA_WORDS)) DUT (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_uart_rx     (uart_rx),
        .o_rx_ack      (rx_ack),
        .o_uart_tx     (uart_tx),
        .i_tx_done     (tx_done),
        .o_imem_wr     (imem_wr),
        .i_core        (core),
        .o_reg_addr    (reg_addr),
        .i_reg_data    (reg_data),
        .o_mem_addr    (mem_addr),
        .i_mem_data    (mem_data),
        .o_core_clk_en (core_clk_en)
    );

    tb_mips_model #(.DATA_WORDS(DATA_WORDS), .HALT_PC(HALT_PC)) u_core (
        .i_clk      (clk),
        .i_reset    (core_reset),
        .i_clk_en   (core_clk_en),
        .o_core     (core),
        .i_reg_addr (reg_addr),
        .o_reg_data (reg_data),
        .i_mem_addr (mem_addr),
        .o_mem_data (mem_data)
    );

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    function automatic void push_word(input logic [WORD_W-1:0] w);
        for (int b = 3; b >= 0; b--) exp_q.push_back(w[8*b +: 8]);
    endfunction

    // Expected dump order is PC, cycle count, registers and data memory, each MSB first
    function automatic void build_dump(input logic [WORD_W-1:0] pc,
                                       input logic [WORD_W-1:0] cycles);
        push_word(pc);
        push_word(cycles);
        for (int i = 0; i < NUM_REGS; i++) push_word(32'(i) * 32'h01010101 + pc);
        for (int j = 0; j < DATA_WORDS; j++) push_word(~32'(j) + cycles);
    endfunction

    task automatic send_byte(input logic [BYTE_W-1:0] b);
        int n;
        @(posedge clk);
        uart_rx.data  <= b;
        uart_rx.valid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rx_ack && n < TIMEOUT);
        if (!rx_ack) report_timeout("no ack for a received byte");
        uart_rx.valid <= 1'b0;  // Dropped right after the ack is seen
    endtask

    task automatic send_word(input logic [WORD_W-1:0] w);
        for (int b = 3; b >= 0; b--) send_byte(w[8*b +: 8]);
    endtask

    task automatic load_program(input int body_words);
        logic [WORD_W-1:0] words[$];
        int                wr0;
        int                n;
        // Top bit cleared so no body word equals the halt word
        for (int i = 0; i < body_words; i++) words.push_back({1'b0, 31'($random(seed))});
        words.push_back(HALT_INSTR);
        wr0 = wr_cnt;
        send_byte(CMD_LOAD);
        foreach (words[i]) send_word(words[i]);
        n = 0;
        while (wr_cnt != wr0 + words.size() && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (wr_cnt != wr0 + words.size()) report_timeout("instruction writes missing");
        repeat (10) @(posedge clk);
        check_equal(wr_cnt - wr0, words.size(), "imem write count");
        foreach (words[i]) begin
            if (wr0 + i < wr_addr_q.size()) begin
                check_equal(32'(wr_addr_q[wr0 + i]), 32'(4 * i), "imem write address");
                check_equal(wr_data_q[wr0 + i], words[i], "imem write data");
            end
        end
    endtask

    task automatic run_and_dump(input logic [BYTE_W-1:0] cmd, input logic [WORD_W-1:0] pc,
                                input logic [WORD_W-1:0] cycles, input int enables);
        int en0;
        int tx0;
        int n;
        en0 = en_cnt;
        tx0 = tx_bytes;
        build_dump(pc, cycles);
        send_byte(cmd);
        n = 0;
        while ((tx_bytes != tx0 + DUMP_BYTES || tx_busy) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (tx_bytes != tx0 + DUMP_BYTES || tx_busy) report_timeout("dump did not complete");
        repeat (20) @(posedge clk);
        check_equal(tx_bytes - tx0, DUMP_BYTES, "dump byte count");
        check_equal(exp_q.size(), 0, "reference bytes not sent");
        check_equal(en_cnt - en0, enables, "core enable cycles");
        exp_q.delete();
    endtask

    // UART transmitter model with a random busy time per byte
    initial begin
        int delay;
        tx_done <= 1'b0;
        forever begin
            @(posedge clk);
            if (uart_tx.start) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) @(posedge clk);
                tx_done <= 1'b1;
                @(posedge clk);
                tx_done <= 1'b0;
            end
        end
    end

    // Compares every transmitted byte and watches the tx handshake
    always @(posedge clk) begin
        if (reset) begin
            tx_busy  <= 1'b0;
            tx_bytes <= 0;
        end else if (uart_tx.start) begin
            if (tx_busy) begin
                errors++;
                $display("Start pulse at %0t before the previous byte was done", $time);
            end
            tx_busy  <= 1'b1;
            tx_bytes <= tx_bytes + 1;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected byte %h sent at %0t", uart_tx.data, $time);
            end else begin
                check_equal(32'(uart_tx.data), 32'(exp_q.pop_front()), "dump byte");
            end
        end else if (tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            en_cnt <= 0;
            wr_cnt <= 0;
        end else begin
            if (core_clk_en) en_cnt <= en_cnt + 1;
            if (imem_wr.we) begin
                wr_cnt <= wr_cnt + 1;
                wr_addr_q.push_back(imem_wr.addr);
                wr_data_q.push_back(imem_wr.data);
            end
        end
    end

    initial begin
        reset      <= 1'b1;
        core_reset <= 1'b1;
        uart_rx    <= '0;
        repeat (16) @(posedge clk);
        reset      <= 1'b0;
        core_reset <= 1'b0;

        repeat (10) @(posedge clk);
        check_equal(en_cnt, 0, "enable cycles while idle");
        check_equal(tx_bytes, 0, "tx starts while idle");
        check_equal(wr_cnt, 0, "imem writes while idle");

        // Unknown bytes are acked and change nothing
        send_byte(8'h78);
        send_byte(8'h00);
        send_byte(CMD_NEXT);
        repeat (20) @(posedge clk);
        check_equal(en_cnt, 0, "enable after unknown bytes");
        check_equal(tx_bytes, 0, "tx after unknown bytes");
        check_equal(wr_cnt, 0, "imem write after unknown bytes");

        load_program(2);
        load_program(1);  // Must restart at address 0

        run_and_dump(CMD_CONTINUOUS, HALT_PC, HALT_PC / 4, int'(HALT_PC / 4));

        @(posedge clk);
        core_reset <= 1'b1;  // Clear halt so stepping can advance
        @(posedge clk);
        core_reset <= 1'b0;
        repeat (2) @(posedge clk);

        send_byte(CMD_STEP);
        for (int k = 1; k <= 3; k++) run_and_dump(CMD_NEXT, 32'(4 * k), 32'(k), 1);

        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/tb_mips_model.sv
`timescale 1ns/1ps

module tb_mips_model
    import dbg_pkg::*;
#(
    parameter int                DATA_WORDS = 16,
    parameter logic [WORD_W-1:0] HALT_PC    = 32'd24,
    localparam int MEM_ADDR_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_clk_en,
    output core_status_t          o_core,
    input  logic [REG_ADDR_W-1:0] i_reg_addr,
    output logic [WORD_W-1:0]     o_reg_data,
    input  logic [MEM_ADDR_W-1:0] i_mem_addr,
    output logic [WORD_W-1:0]     o_mem_data
);

    logic [WORD_W-1:0] pc_q;
    logic [WORD_W-1:0] cycles_q;

    // One instruction per enabled cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q     <= '0;
            cycles_q <= '0;
        end else if (i_clk_en) begin
            pc_q     <= pc_q + 32'd4;
            cycles_q <= cycles_q + 32'd1;
        end
    end

    assign o_core.halt        = (pc_q >= HALT_PC);  // Stays up until the model is reset
    assign o_core.pc          = pc_q;
    assign o_core.cycle_count = cycles_q;

    // Register and memory contents follow the PC and cycle count
    assign o_reg_data = WORD_W'(i_reg_addr) * 32'h01010101 + pc_q;
    assign o_mem_data = ~WORD_W'(i_mem_addr) + cycles_q;

endmodule

// File: hdl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit
    import dbg_pkg::*;
#(
    parameter int IMEM_ADDR_W = 8,
    parameter int DATA_WORDS  = 16,
    localparam int MEM_ADDR_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  uart_rx_t              i_uart_rx,
    output logic                  o_rx_ack,
    output uart_tx_t              o_uart_tx,
    input  logic                  i_tx_done,
    output imem_wr_t              o_imem_wr,
    input  core_status_t          i_core,
    output logic [REG_ADDR_W-1:0] o_reg_addr,
    input  logic [WORD_W-1:0]     i_reg_data,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    input  logic [WORD_W-1:0]     i_mem_data,
    output logic                  o_core_clk_en
);

    logic              byte_strobe;
    logic [BYTE_W-1:0] rx_byte;
    logic              word_done;
    logic              halt_seen;
    logic              dump_start;
    logic              dump_done;
    logic              word_valid;
    logic              word_ready;
    logic [WORD_W-1:0] dump_word;

    dbg_command_fsm u_fsm (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_uart_rx     (i_uart_rx),
        .i_halt        (i_core.halt),
        .i_word_done   (word_done),
        .i_halt_seen   (halt_seen),
        .i_dump_done   (dump_done),
        .o_rx_ack      (o_rx_ack),
        .o_byte_strobe (byte_strobe),
        .o_byte        (rx_byte),
        .o_dump_start  (dump_start),
        .o_core_clk_en (o_core_clk_en)
    );

    dbg_instr_loader #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_loader (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_byte_strobe (byte_strobe),
        .i_byte        (rx_byte),
        .o_imem_wr     (o_imem_wr),
        .o_word_done   (word_done),
        .o_halt_seen   (halt_seen)
    );

    dbg_dump_sequencer #(.DATA_WORDS(DATA_WORDS)) u_dump (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_core       (i_core),
        .i_reg_data   (i_reg_data),
        .i_mem_data   (i_mem_data),
        .i_word_ready (word_ready),
        .o_reg_addr   (o_reg_addr),
        .o_mem_addr   (o_mem_addr),
        .o_word_valid (word_valid),
        .o_word       (dump_word),
        .o_dump_done  (dump_done)
    );

    dbg_tx_serializer u_tx (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_word_valid (word_valid),
        .i_word       (dump_word),
        .i_tx_done    (i_tx_done),
        .o_word_ready (word_ready),
        .o_uart_tx    (o_uart_tx)
    );

endmodule

// File: hdl/dbg_tx_serializer.sv
`timescale 1ns/1ps

module dbg_tx_serializer
    import dbg_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_word_valid,
    input  logic [WORD_W-1:0] i_word,
    input  logic              i_tx_done,
    output logic              o_word_ready,
    output uart_tx_t          o_uart_tx
);

    logic [WORD_W-1:0] shift_q;
    logic [1:0]        byte_cnt_q;
    logic              busy_q;
    logic              start_q;
    logic              take_word;

    assign take_word = i_word_valid && !busy_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt_q <= '0;
            busy_q     <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (take_word) begin
                busy_q     <= 1'b1;
                start_q    <= 1'b1;  // First byte goes out right away
                byte_cnt_q <= '0;
            end else if (busy_q && i_tx_done) begin
                if (byte_cnt_q == 2'd3) begin
                    busy_q <= 1'b0;
                end else begin
                    start_q    <= 1'b1;
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                end
            end
        end
    end

    // Shifts only together with a new start so tx data stays put meanwhile
    always_ff @(posedge i_clk) begin
        if (take_word) begin
            shift_q <= i_word;
        end else if (busy_q && i_tx_done && (byte_cnt_q != 2'd3)) begin
            shift_q <= {shift_q[WORD_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
        end
    end

    assign o_word_ready    = !busy_q;
    assign o_uart_tx.start = start_q;
    assign o_uart_tx.data  = shift_q[WORD_W-1 -: BYTE_W];  // MSB first

endmodule

// File: hdl/dbg_dump_sequencer.sv
`timescale 1ns/1ps

module dbg_dump_sequencer
    import dbg_pkg::*;
#(
    parameter int DATA_WORDS = 16,
    localparam int MEM_ADDR_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_dump_start,
    input  core_status_t          i_core,
    input  logic [WORD_W-1:0]     i_reg_data,
    input  logic [WORD_W-1:0]     i_mem_data,
    input  logic                  i_word_ready,
    output logic [REG_ADDR_W-1:0] o_reg_addr,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output logic                  o_word_valid,
    output logic [WORD_W-1:0]     o_word,
    output logic                  o_dump_done
);

    typedef enum logic [2:0] {PH_IDLE, PH_PC, PH_CYCLES, PH_REGS, PH_MEM, PH_DRAIN} phase_t;

    phase_t                phase_q;
    logic                  valid_q;
    logic                  done_q;
    logic [REG_ADDR_W-1:0] reg_addr_q;
    logic [MEM_ADDR_W-1:0] mem_addr_q;
    logic [WORD_W-1:0]     word_q;
    logic [WORD_W-1:0]     sample;
    logic                  capture;

    always_comb begin
        case (phase_q)
            PH_PC:     sample = i_core.pc;
            PH_CYCLES: sample = i_core.cycle_count;
            PH_REGS:   sample = i_reg_data;
            default:   sample = i_mem_data;
        endcase
    end

    // Address has been stable for the whole cycle when the word is taken
    assign capture = !valid_q && (phase_q != PH_IDLE) && (phase_q != PH_DRAIN);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_q <= PH_IDLE;
            valid_q <= 1'b0;
            done_q <= 1'b0;
            reg_addr_q <= '0;
            mem_addr_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (i_dump_start) begin
                phase_q    <= PH_PC;
                valid_q    <= 1'b0;
                reg_addr_q <= '0;
                mem_addr_q <= '0;
            end else if (phase_q == PH_DRAIN) begin
                if (i_word_ready) begin  // Serializer has sent the last byte
                    phase_q <= PH_IDLE;
                    done_q  <= 1'b1;
                end
            end else if (capture) begin
                valid_q <= 1'b1;
            end else if (valid_q && i_word_ready) begin
                valid_q <= 1'b0;
                case (phase_q)
                    PH_PC:     phase_q <= PH_CYCLES;
                    PH_CYCLES: phase_q <= PH_REGS;
                    PH_REGS: begin
                        if (reg_addr_q == REG_ADDR_W'(NUM_REGS - 1)) phase_q <= PH_MEM;
                        else reg_addr_q <= reg_addr_q + 1'b1;
                    end
                    PH_MEM: begin
                        if (mem_addr_q == MEM_ADDR_W'(DATA_WORDS - 1)) phase_q <= PH_DRAIN;
                        else mem_addr_q <= mem_addr_q + 1'b1;
                    end
                    default: phase_q <= PH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) word_q <= sample;
    end

    assign o_reg_addr   = reg_addr_q;
    assign o_mem_addr   = mem_addr_q;
    assign o_word_valid = valid_q;
    assign o_word       = word_q;
    assign o_dump_done  = done_q;

endmodule

// File: hdl/dbg_instr_loader.sv
`timescale 1ns/1ps

module dbg_instr_loader
    import dbg_pkg::*;
#(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_byte_strobe,
    input  logic [BYTE_W-1:0] i_byte,
    output imem_wr_t          o_imem_wr,
    output logic              o_word_done,
    output logic              o_halt_seen
);

    logic [WORD_W-1:0]      instr_q;
    logic [1:0]             byte_cnt_q;
    logic                   wr_q;
    logic [IMEM_ADDR_W-1:0] addr_q;
    logic                   is_halt;

    assign is_halt = (instr_q == HALT_INSTR);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt_q <= '0;
            wr_q       <= 1'b0;
            addr_q     <= '0;
        end else begin
            wr_q <= i_byte_strobe && (byte_cnt_q == 2'd3);  // Fourth byte completes the word
            if (i_byte_strobe) byte_cnt_q <= byte_cnt_q + 2'd1;
            if (wr_q) begin
                addr_q <= is_halt ? '0 : addr_q + IMEM_ADDR_W'(4);  // Next load starts at 0
            end
        end
    end

    // First byte received ends up in the top byte
    always_ff @(posedge i_clk) begin
        if (i_byte_strobe) instr_q <= {instr_q[WORD_W-BYTE_W-1:0], i_byte};
    end

    assign o_imem_wr.we   = wr_q;
    assign o_imem_wr.addr = addr_q;
    assign o_imem_wr.data = instr_q;
    assign o_word_done    = wr_q;
    assign o_halt_seen    = wr_q && is_halt;

endmodule

// File: hdl/dbg_command_fsm.sv
`timescale 1ns/1ps

module dbg_command_fsm
    import dbg_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  uart_rx_t          i_uart_rx,
    input  logic              i_halt,
    input  logic              i_word_done,
    input  logic              i_halt_seen,
    input  logic              i_dump_done,
    output logic              o_rx_ack,
    output logic              o_byte_strobe,
    output logic [BYTE_W-1:0] o_byte,
    output logic              o_dump_start,
    output logic              o_core_clk_en
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CONT,
        ST_STEP_WAIT,
        ST_STEP_PULSE,
        ST_DUMP
    } state_t;

    state_t state_q;
    logic   rx_ack_q;
    logic   dump_start_q;
    logic   step_mode_q;   // Dump returns to step-wait instead of idle
    logic   accept;
    logic   take;

    // Only these states consume UART bytes
    assign accept = (state_q == ST_IDLE) || (state_q == ST_LOAD) ||
                    (state_q == ST_STEP_WAIT);
    assign take   = i_uart_rx.valid && !rx_ack_q && accept;  // Valid is stale while ack is high

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q      <= ST_IDLE;
            rx_ack_q     <= 1'b0;
            dump_start_q <= 1'b0;
            step_mode_q  <= 1'b0;
        end else begin
            rx_ack_q     <= take;
            dump_start_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (take) begin
                        case (i_uart_rx.data)
                            CMD_LOAD: state_q <= ST_LOAD;
                            CMD_CONTINUOUS: begin
                                state_q     <= ST_CONT;
                                step_mode_q <= 1'b0;
                            end
                            CMD_STEP: begin
                                state_q     <= ST_STEP_WAIT;
                                step_mode_q <= 1'b1;
                            end
                            default: state_q <= ST_IDLE;  // Unknown byte is acked and dropped
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (i_word_done && i_halt_seen) state_q <= ST_IDLE;
                end
                ST_CONT: begin
                    if (i_halt) begin
                        state_q      <= ST_DUMP;
                        dump_start_q <= 1'b1;
                    end
                end
                ST_STEP_WAIT: begin
                    if (take && (i_uart_rx.data == CMD_NEXT)) state_q <= ST_STEP_PULSE;
                end
                ST_STEP_PULSE: begin
                    state_q      <= ST_DUMP;  // Core has taken its single enabled cycle
                    dump_start_q <= 1'b1;
                end
                ST_DUMP: begin
                    if (i_dump_done) begin
                        state_q <= (step_mode_q && !i_halt) ? ST_STEP_WAIT : ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign o_rx_ack      = rx_ack_q;
    assign o_byte_strobe = take && (state_q == ST_LOAD);
    assign o_byte        = i_uart_rx.data;
    assign o_dump_start  = dump_start_q;
    assign o_core_clk_en = (state_q == ST_STEP_PULSE) ||
                           ((state_q == ST_CONT) && !i_halt);  // Drops as soon as halt shows

endmodule

// File: hdl/dbg_pkg.sv
package dbg_pkg;

    localparam int WORD_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    localparam logic [BYTE_W-1:0] CMD_CONTINUOUS = 8'h63;  // 'c'
    localparam logic [BYTE_W-1:0] CMD_STEP       = 8'h73;  // 's'
    localparam logic [BYTE_W-1:0] CMD_LOAD       = 8'h64;  // 'd'
    localparam logic [BYTE_W-1:0] CMD_NEXT       = 8'h6e;  // 'n'

    localparam logic [WORD_W-1:0] HALT_INSTR = '1;  // Last word of a program load

    typedef struct packed {
        logic              valid;  // Held until the ack pulse is seen
        logic [BYTE_W-1:0] data;
    } uart_rx_t;

    typedef struct packed {
        logic              start;  // One-cycle pulse per byte
        logic [BYTE_W-1:0] data;
    } uart_tx_t;

    typedef struct packed {
        logic              we;
        logic [7:0]        addr;  // Byte address into instruction memory
        logic [WORD_W-1:0] data;
    } imem_wr_t;

    typedef struct packed {
        logic              halt;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] cycle_count;
    } core_status_t;

endpackage
